//--- vlog.f
rename_pkg.sv
inst_decoder.sv
free_list.sv
map_table.sv
cdb_arbiter.sv
rename_top.sv
rename_assertions.sv
rename_tb.sv

//--- rename_tb.sv
// register rename testbench
// table-driven directed checks, then a shadow-model phase covering
// free-list exhaustion and random dispatch and retire traffic
`timescale 1ns/1ps
`include "rename_macros.svh"

module rename_tb;

  localparam int PERIOD  = 100;
  localparam int N_FILL  = 35;
  localparam int N_RAND  = 48;
  localparam int N_TOTAL = 16 + N_FILL + N_RAND + 8;

  typedef struct {
    logic [31:0] inst;
    logic        disp;
    logic [2:0]  rob;
    logic [1:0]  req;
    logic [5:0]  tag0;
    logic [4:0]  rd0;
    logic [5:0]  tag1;
    logic [4:0]  rd1;
    logic        ret;
    logic [5:0]  ret_tag;
    logic        rb;
    logic [2:0]  rb_tag;
    logic [5:0]  dest;
    logic [5:0]  old;
    logic [5:0]  s1;
    logic        r1;
    logic [5:0]  s2;
    logic        r2;
    logic        alloc;
    logic        stl;
    logic [1:0]  grant;
    logic [5:0]  cdb;
    logic [4:0]  cdbrd;
  } row_t;

  logic clock, reset;
  rename_pkg::inst_word_u inst;
  logic dispatch_en, retire_en, rollback_en;
  rename_pkg::rob_tag_t rob_tag, rollback_tag;
  rename_pkg::phys_tag_t src1_tag, src2_tag, dest_tag, old_tag, cdb_tag, retire_tag;
  rename_pkg::phys_tag_t cpl_tag0, cpl_tag1;
  rename_pkg::arch_idx_t cpl_rd0, cpl_rd1, cdb_rd;
  logic src1_ready, src2_ready, alloc, stall, cdb_valid;
  logic [1:0] cpl_req, cpl_grant;

  row_t rows[$];
  int errors = 0;
  // shadow state: map tags, ready bits, free tags, old tags awaiting retire
  logic [5:0] smap [32];
  logic       srdy [32];
  logic [5:0] sfree[$];
  logic [5:0] pend[$];

  rename_top i_rename_top (.*);

  bind free_list rename_assertions i_free_list_assertions (
    .clock(clock), .reset(reset), .stall(stall), .rollback(rollback_en),
    .head(head), .count(count), .cpl_req(2'b00), .cpl_grant(2'b00));
  bind cdb_arbiter rename_assertions i_cdb_arbiter_assertions (
    .clock(clock), .reset(reset), .stall(1'b0), .rollback(1'b0),
    .head('0), .count('0), .cpl_req(cpl_req), .cpl_grant(cpl_grant));

  initial begin
    clock = 1'b0;
    forever #(PERIOD/2) clock = ~clock;
  end

  // watchdog sized from the number of cycles the tests take
  initial begin
    #(N_TOTAL * PERIOD + 10 * PERIOD);
    $display("watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

  function automatic logic [31:0] r_op(input int rd, input int rs1, input int rs2);
    return {7'd0, 5'(rs2), 5'(rs1), 3'd0, 5'(rd), 7'b0110011};
  endfunction

  function automatic logic [31:0] i_op(input int rd, input int rs1, input logic [11:0] imm);
    return {imm, 5'(rs1), 3'd0, 5'(rd), 7'b0010011};
  endfunction

  task automatic check(input string name, input logic [31:0] actual, input logic [31:0] expected);
    if (actual !== expected) begin
      errors++;
      $display("FAILED t=%0t %s: got %0h expected %0h", $time, name, actual, expected);
    end
  endtask

  task automatic idle_inputs();
    inst = '0;
    dispatch_en = 0;
    rob_tag = '0;
    cpl_req = '0;
    cpl_tag0 = '0;
    cpl_tag1 = '0;
    cpl_rd0 = '0;
    cpl_rd1 = '0;
    retire_en = 0;
    retire_tag = '0;
    rollback_en = 0;
    rollback_tag = '0;
  endtask

  task automatic do_reset();
    @(negedge clock);
    reset = 1'b1;
    idle_inputs();
    repeat (2) @(negedge clock);
    reset = 1'b0;
    for (int i = 0; i < 32; i++) begin
      smap[i] = 6'(i);
      srdy[i] = 1'b1;
    end
    sfree = {};
    pend = {};
    for (int i = 32; i < 64; i++) sfree.push_back(6'(i));
  endtask

  // one cycle against the shadow model, no cdb traffic
  task automatic shadow_step(input logic [31:0] word, input logic disp,
                             input logic ret, input logic [5:0] rtag);
    logic [6:0] opc;
    logic is_op, is_imm, wr, e_stall, e_alloc;
    logic [4:0] rd, rs1, rs2;
    opc    = word[6:0];
    is_op  = (opc == 7'b0110011);
    is_imm = (opc == 7'b0010011);
    rd  = (is_op || is_imm) ? word[11:7] : 5'd0;
    rs1 = (is_op || is_imm) ? word[19:15] : 5'd0;
    rs2 = is_op ? word[24:20] : 5'd0;
    wr  = (is_op || is_imm) && (rd != 0);
    e_stall = disp && wr && (sfree.size() == 0);
    e_alloc = disp && wr && !e_stall;
    @(negedge clock);
    inst = word;
    dispatch_en = disp;
    rob_tag = 3'($urandom);
    retire_en = ret;
    retire_tag = rtag;
    #10;
    check("src1_tag", src1_tag, smap[rs1]);
    check("src1_ready", src1_ready, srdy[rs1]);
    check("src2_tag", src2_tag, smap[rs2]);
    check("src2_ready", src2_ready, srdy[rs2]);
    check("old_tag", old_tag, smap[rd]);
    check("stall", stall, e_stall);
    check("alloc", alloc, e_alloc);
    if (sfree.size() != 0) check("dest_tag", dest_tag, sfree[0]);
    @(posedge clock);
    if (e_alloc) begin
      pend.push_back(smap[rd]);
      smap[rd] = sfree.pop_front();
      srdy[rd] = 1'b0;
    end
    if (ret) sfree.push_back(rtag);
  endtask

  initial begin
    row_t r;
    logic [31:0] word;
    logic [5:0] rtag;
    logic ret;
    int assert_fails;
    void'($urandom(32'h9249_66c2));
    reset = 1'b1;
    idle_inputs();
    // inputs | dest old s1 r1 s2 r2 alloc stall grant cdb cdb_rd
    rows.push_back('{r_op(1,2,3), 1,0, 0,0,0,0,0, 0,0,0,0, 32,1,2,1,3,1, 1,0,0,0,0});
    rows.push_back('{r_op(4,1,5), 1,1, 0,0,0,0,0, 0,0,0,0, 33,4,32,0,5,1, 1,0,0,0,0});
    rows.push_back('{i_op(6,1,12'hfff), 1,2, 0,0,0,0,0, 0,0,0,0, 34,6,32,0,0,1, 1,0,0,0,0});
    // x0 destination still dispatches, no tag taken
    rows.push_back('{r_op(0,4,6), 1,3, 0,0,0,0,0, 0,0,0,0, 35,0,33,0,34,0, 0,0,0,0,0});
    // uncontested completion, forwarded to src1
    rows.push_back('{r_op(7,1,4), 1,4, 1,32,1,0,0, 0,0,0,0, 35,7,32,1,33,0, 1,0,1,32,1});
    // contested, pointer favours unit 0 first
    rows.push_back('{r_op(8,4,6), 0,0, 3,33,4,34,6, 0,0,0,0, 36,8,33,1,34,0, 0,0,1,33,4});
    rows.push_back('{r_op(8,4,6), 0,0, 3,35,7,34,6, 0,0,0,0, 36,8,33,1,34,1, 0,0,2,34,6});
    rows.push_back('{r_op(9,7,1), 0,0, 3,35,7,20,20, 0,0,0,0, 36,9,35,1,32,1, 0,0,1,35,7});
    rows.push_back('{r_op(9,7,20), 0,0, 2,0,0,20,20, 0,0,0,0, 36,9,35,1,20,1, 0,0,2,20,20});
    // rollback to rob 1 blocks this dispatch
    rows.push_back('{r_op(10,6,7), 1,5, 0,0,0,0,0, 0,0,1,1, 36,10,34,1,35,1, 0,0,0,0,0});
    rows.push_back('{r_op(11,6,7), 1,5, 0,0,0,0,0, 0,0,0,0, 34,11,6,1,7,1, 1,0,0,0,0});
    rows.push_back('{r_op(12,1,4), 1,6, 0,0,0,0,0, 0,0,0,0, 35,12,32,1,33,1, 1,0,0,0,0});
    // store opcode passes through
    rows.push_back('{32'h0031_2223, 1,7, 0,0,0,0,0, 0,0,0,0, 36,0,0,1,0,1, 0,0,0,0,0});

    repeat (2) @(posedge clock);
    foreach (rows[i]) begin
      r = rows[i];
      @(negedge clock);
      reset = 1'b0;
      inst = r.inst;
      dispatch_en = r.disp;
      rob_tag = r.rob;
      cpl_req = r.req;
      cpl_tag0 = r.tag0;
      cpl_rd0 = r.rd0;
      cpl_tag1 = r.tag1;
      cpl_rd1 = r.rd1;
      retire_en = r.ret;
      retire_tag = r.ret_tag;
      rollback_en = r.rb;
      rollback_tag = r.rb_tag;
      #10;
      check("dest_tag", dest_tag, r.dest);
      check("old_tag", old_tag, r.old);
      check("src1_tag", src1_tag, r.s1);
      check("src1_ready", src1_ready, r.r1);
      check("src2_tag", src2_tag, r.s2);
      check("src2_ready", src2_ready, r.r2);
      check("alloc", alloc, r.alloc);
      check("stall", stall, r.stl);
      check("cpl_grant", cpl_grant, r.grant);
      check("cdb_valid", cdb_valid, r.grant != 2'b00);
      if (r.grant != 2'b00) begin
        check("cdb_tag", cdb_tag, r.cdb);
        check("cdb_rd", cdb_rd, r.cdbrd);
      end
    end

    // exhaust the free list, stall, then retire one tag and reuse it
    do_reset();
    for (int i = 0; i < 32; i++) shadow_step(r_op(i % 31 + 1, (i * 7) % 32, i), 1, 0, 0);
    shadow_step(r_op(5, 1, 2), 1, 0, 0);
    shadow_step(r_op(5, 1, 2), 1, 1, pend.pop_front());
    shadow_step(r_op(5, 1, 2), 1, 0, 0);

    // random dispatch and retire traffic
    for (int i = 0; i < N_RAND; i++) begin
      case ($urandom % 3)
        0: word = r_op($urandom % 32, $urandom % 32, $urandom % 32);
        1: word = i_op($urandom % 32, $urandom % 32, 12'($urandom));
        default: word = {$urandom} & 32'hffff_ff80 | 32'h0000_0063;
      endcase
      ret  = (pend.size() != 0) && ($urandom % 2 == 0);
      rtag = ret ? pend.pop_front() : 6'd0;
      shadow_step(word, ($urandom % 4) != 0, ret, rtag);
    end

    @(negedge clock);
    idle_inputs();
    assert_fails = i_rename_top.i_free_list.i_free_list_assertions.fail_count
                 + i_rename_top.i_cdb_arbiter.i_cdb_arbiter_assertions.fail_count;
    $display("rename test finished with %0d check errors and %0d assertion failures",
             errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- rename_assertions.sv
// rename protocol assertions
// bound into free_list and cdb_arbiter; each binding ties off the
// signals that its target does not own
`timescale 1ns/1ps
`include "rename_macros.svh"

module rename_assertions (
  input logic                clock,
  input logic                reset,
  input logic                stall,
  input logic                rollback,
  input logic [`PR_BITS-1:0] head,
  input logic [`PR_BITS:0]   count,
  input logic [1:0]          cpl_req,
  input logic [1:0]          cpl_grant
);

  // failures seen so far, read by the testbench at the end
  int unsigned fail_count = 0;

  // a stalled dispatch leaves the head where it was
  no_pop_on_stall: assert property (@(posedge clock) disable iff (reset)
    (stall && !rollback) |=> (head == $past(head)))
    else begin
      fail_count++;
      $error("free list head moved after a stalled dispatch");
    end

  // queue occupancy bounded by its depth
  count_in_range: assert property (@(posedge clock) disable iff (reset)
    count <= `NUM_PR)
    else begin
      fail_count++;
      $error("free list count above queue depth");
    end

  // back-to-back contention hands the bus to the other unit
  grant_alternates: assert property (@(posedge clock) disable iff (reset)
    (cpl_req == 2'b11) ##1 (cpl_req == 2'b11) |-> (cpl_grant != $past(cpl_grant)))
    else begin
      fail_count++;
      $error("contested cdb grant did not alternate between units");
    end

endmodule

//--- rename_top.sv
// register rename block top
// decoder, free list, map table and cdb arbiter; the testbench stands in
// for the front end, the rob and the execution units
`timescale 1ns/1ps

module rename_top (
  input  logic                   clock,
  input  logic                   reset,
  // dispatch
  input  rename_pkg::inst_word_u inst,
  input  logic                   dispatch_en,
  input  rename_pkg::rob_tag_t   rob_tag,
  // rename results
  output rename_pkg::phys_tag_t  src1_tag,
  output logic                   src1_ready,
  output rename_pkg::phys_tag_t  src2_tag,
  output logic                   src2_ready,
  output rename_pkg::phys_tag_t  dest_tag,
  output rename_pkg::phys_tag_t  old_tag,
  output logic                   alloc,
  output logic                   stall,
  // completions
  input  logic [1:0]             cpl_req,
  input  rename_pkg::phys_tag_t  cpl_tag0,
  input  rename_pkg::phys_tag_t  cpl_tag1,
  input  rename_pkg::arch_idx_t  cpl_rd0,
  input  rename_pkg::arch_idx_t  cpl_rd1,
  output logic [1:0]             cpl_grant,
  output logic                   cdb_valid,
  output rename_pkg::phys_tag_t  cdb_tag,
  output rename_pkg::arch_idx_t  cdb_rd,
  // retire and rollback
  input  logic                   retire_en,
  input  rename_pkg::phys_tag_t  retire_tag,
  input  logic                   rollback_en,
  input  rename_pkg::rob_tag_t   rollback_tag
);

  rename_pkg::arch_idx_t rd;
  rename_pkg::arch_idx_t rs1;
  rename_pkg::arch_idx_t rs2;
  logic                  writes_rd;
  logic                  dispatch_fire;

  // rs2 use is folded into rs2 itself
  inst_decoder i_inst_decoder (
    .inst      (inst),
    .rd        (rd),
    .rs1       (rs1),
    .rs2       (rs2),
    .writes_rd (writes_rd),
    .uses_rs2  ()
  );

  free_list i_free_list (
    .clock         (clock),
    .reset         (reset),
    .dispatch_en   (dispatch_en),
    .writes_rd     (writes_rd),
    .rollback_en   (rollback_en),
    .retire_en     (retire_en),
    .rob_tag       (rob_tag),
    .rollback_tag  (rollback_tag),
    .retire_tag    (retire_tag),
    .dispatch_fire (dispatch_fire),
    .alloc_fire    (alloc),
    .stall         (stall),
    .free_tag      (dest_tag)
  );

  map_table i_map_table (
    .clock         (clock),
    .reset         (reset),
    .alloc_fire    (alloc),
    .dispatch_fire (dispatch_fire),
    .rollback_en   (rollback_en),
    .cdb_valid     (cdb_valid),
    .rd            (rd),
    .rs1           (rs1),
    .rs2           (rs2),
    .free_tag      (dest_tag),
    .cdb_tag       (cdb_tag),
    .cdb_rd        (cdb_rd),
    .rob_tag       (rob_tag),
    .rollback_tag  (rollback_tag),
    .src1_tag      (src1_tag),
    .src2_tag      (src2_tag),
    .old_tag       (old_tag),
    .src1_ready    (src1_ready),
    .src2_ready    (src2_ready)
  );

  cdb_arbiter i_cdb_arbiter (
    .clock     (clock),
    .reset     (reset),
    .cpl_req   (cpl_req),
    .cpl_tag0  (cpl_tag0),
    .cpl_tag1  (cpl_tag1),
    .cpl_rd0   (cpl_rd0),
    .cpl_rd1   (cpl_rd1),
    .cpl_grant (cpl_grant),
    .cdb_valid (cdb_valid),
    .cdb_tag   (cdb_tag),
    .cdb_rd    (cdb_rd)
  );

endmodule

//--- cdb_arbiter.sv
// completion bus arbiter
// two execution units share one cdb; round robin on contention,
// grant and bus are combinational from the requests
`timescale 1ns/1ps

module cdb_arbiter (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [1:0]            cpl_req,
  input  rename_pkg::phys_tag_t cpl_tag0,
  input  rename_pkg::phys_tag_t cpl_tag1,
  input  rename_pkg::arch_idx_t cpl_rd0,
  input  rename_pkg::arch_idx_t cpl_rd1,
  output logic [1:0]            cpl_grant,
  output logic                  cdb_valid,
  output rename_pkg::phys_tag_t cdb_tag,
  output rename_pkg::arch_idx_t cdb_rd
);

  // which unit wins the next tie, 0 favours unit 0
  logic ptr;

  always_comb begin
    case (cpl_req)
      2'b01:   cpl_grant = 2'b01;
      2'b10:   cpl_grant = 2'b10;
      2'b11:   cpl_grant = ptr ? 2'b10 : 2'b01;
      default: cpl_grant = 2'b00;
    endcase
  end

  // any request gets the bus this cycle
  assign cdb_valid = |cpl_req;

  // winner's payload onto the bus
  assign cdb_tag = cpl_grant[1] ? cpl_tag1 : cpl_tag0;
  assign cdb_rd  = cpl_grant[1] ? cpl_rd1 : cpl_rd0;

  // flip only when both wanted the bus
  always_ff @(posedge clock) begin
    if (reset) begin
      ptr <= 1'b0;
    end else if (&cpl_req) begin
      ptr <= ~ptr;
    end
  end

endmodule

//--- map_table.sv
// rename map table
// maps each architectural register to a physical tag plus ready bit,
// wakes entries from the cdb and snapshots the map per rob tag so a
// rollback can restore it in one cycle
`timescale 1ns/1ps
`include "rename_macros.svh"

module map_table (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  alloc_fire,
  input  logic                  dispatch_fire,
  input  logic                  rollback_en,
  input  logic                  cdb_valid,
  input  rename_pkg::arch_idx_t rd,
  input  rename_pkg::arch_idx_t rs1,
  input  rename_pkg::arch_idx_t rs2,
  input  rename_pkg::phys_tag_t free_tag,
  input  rename_pkg::phys_tag_t cdb_tag,
  input  rename_pkg::arch_idx_t cdb_rd,
  input  rename_pkg::rob_tag_t  rob_tag,
  input  rename_pkg::rob_tag_t  rollback_tag,
  output rename_pkg::phys_tag_t src1_tag,
  output rename_pkg::phys_tag_t src2_tag,
  output rename_pkg::phys_tag_t old_tag,
  output logic                  src1_ready,
  output logic                  src2_ready
);

  rename_pkg::map_entry_t map_q [`NUM_ARCH];
  rename_pkg::map_entry_t map_next [`NUM_ARCH];
  rename_pkg::map_entry_t ckpt [`NUM_ROB][`NUM_ARCH];

  // source lookup
  assign src1_tag = map_q[rs1].tag;
  assign src2_tag = map_q[rs2].tag;

  // previous mapping of rd, goes to the rob for freeing at retire
  assign old_tag = map_q[rd].tag;

  // same-cycle cdb forwarding on tag match
  assign src1_ready = map_q[rs1].ready || (cdb_valid && (cdb_tag == map_q[rs1].tag));
  assign src2_ready = map_q[rs2].ready || (cdb_valid && (cdb_tag == map_q[rs2].tag));

  always_comb begin
    map_next = map_q;
    if (rollback_en) begin
      // whole map from the snapshot, all ready
      map_next = ckpt[rollback_tag];
    end else begin
      // wakeup only if rd was not renamed again since
      if (cdb_valid && (map_q[cdb_rd].tag == cdb_tag)) begin
        map_next[cdb_rd].ready = 1'b1;
      end
      // new tag, not ready until its cdb broadcast
      // rd is never x0 here
      if (alloc_fire) begin
        map_next[rd] = '{tag: free_tag, ready: 1'b0};
      end
    end
  end

  // identity map after reset, everything ready
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_ARCH; i++) begin
        map_q[i] <= '{tag: rename_pkg::phys_tag_t'(i), ready: 1'b1};
      end
    end else begin
      map_q <= map_next;
    end
  end

  // snapshot includes this dispatch's own rename
  // ready forced high: older producers are done by the time a rollback lands
  always_ff @(posedge clock) begin
    if (dispatch_fire) begin
      for (int i = 0; i < `NUM_ARCH; i++) begin
        ckpt[rob_tag][i] <= '{tag: map_next[i].tag, ready: 1'b1};
      end
    end
  end

endmodule

//--- free_list.sv
// physical tag free list
// circular queue of free tags, popped at dispatch and pushed at retire;
// keeps the post-dispatch head per rob tag for rollback
`timescale 1ns/1ps
`include "rename_macros.svh"

module free_list (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  dispatch_en,
  input  logic                  writes_rd,
  input  logic                  rollback_en,
  input  logic                  retire_en,
  input  rename_pkg::rob_tag_t  rob_tag,
  input  rename_pkg::rob_tag_t  rollback_tag,
  input  rename_pkg::phys_tag_t retire_tag,
  output logic                  dispatch_fire,
  output logic                  alloc_fire,
  output logic                  stall,
  output rename_pkg::phys_tag_t free_tag
);

  rename_pkg::phys_tag_t queue [`NUM_PR];
  rename_pkg::phys_tag_t head_ckpt [`NUM_ROB];
  rename_pkg::phys_tag_t head;
  rename_pkg::phys_tag_t tail;
  rename_pkg::phys_tag_t head_next;
  rename_pkg::phys_tag_t tail_next;
  logic [`PR_BITS:0]     count;
  logic                  empty;

  assign empty = (count == '0);

  // only a renaming instruction needs a tag
  assign stall = dispatch_en && writes_rd && empty;

  // rollback wins over dispatch
  assign dispatch_fire = dispatch_en && !stall && !rollback_en;
  assign alloc_fire    = dispatch_fire && writes_rd;

  assign free_tag = queue[head];

  // pointers wrap at NUM_PR through their width
  assign head_next = alloc_fire ? head + 1'b1 : head;
  assign tail_next = retire_en ? tail + 1'b1 : tail;

  always_ff @(posedge clock) begin
    if (reset) begin
      head  <= '0;
      tail  <= rename_pkg::phys_tag_t'(`NUM_PR - `NUM_ARCH);
      count <= (`PR_BITS+1)'(`NUM_PR - `NUM_ARCH);
    end else if (rollback_en) begin
      // tags popped after the checkpoint come back
      head  <= head_ckpt[rollback_tag];
      tail  <= tail_next;
      count <= {1'b0, rename_pkg::phys_tag_t'(tail_next - head_ckpt[rollback_tag])};
    end else begin
      head  <= head_next;
      tail  <= tail_next;
      count <= count + (`PR_BITS+1)'(retire_en) - (`PR_BITS+1)'(alloc_fire);
    end
  end

  // queue loaded with 32..63 at reset, so first pop is 32
  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `NUM_PR; i++) begin
        queue[i] <= rename_pkg::phys_tag_t'(i + `NUM_ARCH);
      end
    end else if (retire_en) begin
      queue[tail] <= retire_tag;
    end
  end

  // head as it stands after this dispatch
  // written for non-renaming dispatches too
  always_ff @(posedge clock) begin
    if (dispatch_fire) begin
      head_ckpt[rob_tag] <= head_next;
    end
  end

endmodule

//--- inst_decoder.sv
// instruction decoder for rename
// pulls rd, rs1 and rs2 out of OP and OP-IMM words, flags rd write and
// rs2 use; register numbers not used by the instruction read as x0
`timescale 1ns/1ps
`include "rename_macros.svh"

module inst_decoder (
  input  rename_pkg::inst_word_u inst,
  output rename_pkg::arch_idx_t  rd,
  output rename_pkg::arch_idx_t  rs1,
  output rename_pkg::arch_idx_t  rs2,
  output logic                   writes_rd,
  output logic                   uses_rs2
);

  logic is_op;
  logic is_imm;

  // register-register form
  assign is_op  = (inst.r_view.opcode == `OPC_OP);
  // immediate form, rs2 bits belong to imm
  assign is_imm = (inst.i_view.opcode == `OPC_OP_IMM);

  assign uses_rs2 = is_op;

  // x0 as destination never allocates
  assign writes_rd = (is_op || is_imm) && (inst.i_view.rd != '0);

  // unused fields forced to x0, which is always ready
  assign rd  = (is_op || is_imm) ? inst.i_view.rd : '0;
  assign rs1 = (is_op || is_imm) ? inst.i_view.rs1 : '0;
  assign rs2 = uses_rs2 ? inst.r_view.rs2 : '0;

endmodule

//--- rename_pkg.sv
// register rename types
// tags, map entries and the 32-bit instruction word seen two ways
`include "rename_macros.svh"

package rename_pkg;

  // physical register tag
  typedef logic [`PR_BITS-1:0] phys_tag_t;

  // architectural register number
  typedef logic [4:0] arch_idx_t;

  // rob slot, also the checkpoint index
  typedef logic [`ROB_BITS-1:0] rob_tag_t;

  // one map table slot
  typedef struct packed {
    phys_tag_t tag;
    logic      ready;    // value already on the cdb
  } map_entry_t;

  // r-type field layout
  typedef struct packed {
    logic [6:0] funct7;
    arch_idx_t  rs2;
    arch_idx_t  rs1;
    logic [2:0] funct3;
    arch_idx_t  rd;
    logic [6:0] opcode;
  } r_fields_t;

  // i-type field layout, rs2 slot is immediate here
  typedef struct packed {
    logic [11:0] imm;
    arch_idx_t   rs1;
    logic [2:0]  funct3;
    arch_idx_t   rd;
    logic [6:0]  opcode;
  } i_fields_t;

  typedef union packed {
    r_fields_t r_view;
    i_fields_t i_view;
  } inst_word_u;

endpackage

//--- rename_macros.svh
// register rename sizing
// architectural, physical and rob counts with their index widths,
// plus the two renamed major opcodes
`ifndef RENAME_MACROS_SVH
`define RENAME_MACROS_SVH

// architectural integer registers, x0 included
`define NUM_ARCH 32

// physical register file depth
`define NUM_PR 64
`define PR_BITS 6

// rob entries, one checkpoint slot each
`define NUM_ROB 8
`define ROB_BITS 3

// rv32 major opcodes that get renamed
`define OPC_OP     7'b0110011
`define OPC_OP_IMM 7'b0010011

`endif
